/* icache_top.f */
icache_geom_pkg.sv
icache_ctrl_pkg.sv
icache_way.sv
icache_lru.sv
icache_ctrl.sv
icache_top.sv
icache_clock_gen.sv
icache_props.sv
icache_tb.sv

/* run.sh */
#!/bin/sh
# Builds the cache testbench with Verilator, runs it and checks the log
cd "$(dirname "$0")" || exit 1
rm -f sim.log

verilator --binary --assert --top-module icache_tb -f icache_top.f \
    --Mdir obj_dir -o icache_sim > build.log 2>&1 \
    || { cat build.log; echo "Build failed"; exit 1; }

# An abnormal end, such as a failed assertion, counts as a failure
./obj_dir/icache_sim > sim.log 2>&1 || echo "Test failed" >> sim.log
cat sim.log

grep -q "Test failed" sim.log && { echo "FAIL"; exit 1; }
echo "PASS"

/* icache_tb.sv */
`timescale 1ns/1ns
`default_nettype none

module icache_tb
    import icache_geom_pkg::*;
();

    localparam int    period_ns    = 8;
    localparam int    reset_cycles = 2;
    localparam int    max_gap      = 3;    // Idle cycles allowed before each line word
    localparam int    worst_fill   = words_per_line * (max_gap + 1) + 4;
    localparam int    num_requests = 80;   // Upper bound over all tests
    localparam int    timeout_ns   = (num_requests * worst_fill + 10) * period_ns;
    localparam word_t model_key    = 32'h5a3c_96e1;

    logic       clock;
    logic       reset;
    word_addr_t cpu_addr;
    logic       cpu_read;
    logic       cpu_uncached;
    logic       cpu_inval;
    word_t      cpu_data;
    logic       cpu_ready;
    word_addr_t mem_addr;
    logic       mem_read_line;
    logic       mem_read_word;
    word_t      mem_data;
    offset_t    mem_offset;
    logic       mem_ready;

    integer     seed = 32'hc5ba0974;
    int         errors = 0;
    int         checks = 0;
    int         line_reqs = 0;
    int         word_reqs = 0;
    word_addr_t last_line_addr;
    word_addr_t last_word_addr;

    icache_clock_gen #(.period_ns(period_ns), .reset_cycles(reset_cycles)) clock_gen (
        .clock (clock),
        .reset (reset)
    );

    icache_top icache_top_inst (
        .clock         (clock),
        .reset         (reset),
        .cpu_addr      (cpu_addr),
        .cpu_read      (cpu_read),
        .cpu_uncached  (cpu_uncached),
        .cpu_inval     (cpu_inval),
        .cpu_data      (cpu_data),
        .cpu_ready     (cpu_ready),
        .mem_addr      (mem_addr),
        .mem_read_line (mem_read_line),
        .mem_read_word (mem_read_word),
        .mem_data      (mem_data),
        .mem_offset    (mem_offset),
        .mem_ready     (mem_ready)
    );

    function automatic word_addr_t make_addr(tag_t tag, index_t index, offset_t offset);
        return {tag, index, offset};
    endfunction

    // Memory contents, each word differs from its address
    function automatic word_t model_word(word_addr_t addr);
        return word_t'(addr) ^ model_key;
    endfunction

    task automatic check_word(input string name, input word_t actual, input word_t expected);
        checks++;
        if (actual !== expected) begin
            errors++;
            $display("FAIL %0t %s got %h expected %h", $time, name, actual, expected);
        end
    endtask

    task automatic check_addr(input string name, input word_addr_t actual,
                              input word_addr_t expected);
        checks++;
        if (actual !== expected) begin
            errors++;
            $display("FAIL %0t %s got %h expected %h", $time, name, actual, expected);
        end
    endtask

    task automatic check_count(input string name, input int actual, input int expected);
        checks++;
        if (actual != expected) begin
            errors++;
            $display("FAIL %0t %s got %0d expected %0d", $time, name, actual, expected);
        end
    endtask

    // Line words start at a random offset, odd stride covers all four
    task automatic serve_line(input word_addr_t addr);
        int      rotation;
        int      stride;
        int      gap;
        offset_t offset;
        rotation = {$random(seed)} % words_per_line;
        stride   = (($random(seed) & 1) != 0) ? 3 : 1;
        for (int i = 0; i < words_per_line; i++) begin
            gap    = {$random(seed)} % (max_gap + 1);
            offset = offset_t'(rotation + i * stride);
            repeat (gap) begin
                @(negedge clock);
                mem_ready = 1'b0;
            end
            @(negedge clock);
            mem_ready  = 1'b1;
            mem_offset = offset;
            mem_data   = model_word({addr[addr_bits-1:offset_bits], offset});
        end
        @(negedge clock);
        mem_ready = 1'b0;
    endtask

    task automatic serve_word(input word_addr_t addr);
        @(negedge clock);
        mem_ready  = 1'b1;
        mem_offset = addr[offset_bits-1:0];
        mem_data   = model_word(addr);
        @(negedge clock);
        mem_ready = 1'b0;
    endtask

    // Memory model, requests seen on the falling edge
    initial begin
        mem_ready  = 1'b0;
        mem_offset = '0;
        mem_data   = '0;
        forever begin
            @(negedge clock);
            if (!reset && mem_read_line) begin
                line_reqs++;
                last_line_addr = mem_addr;
                serve_line(mem_addr);
            end else if (!reset && mem_read_word) begin
                word_reqs++;
                last_word_addr = mem_addr;
                serve_word(mem_addr);
            end
        end
    end

    task automatic run_request(input word_addr_t addr, input logic read, input logic uncached,
                               input logic inval, output word_t data, output int latency);
        logic ready;
        ready   = 1'b0;
        latency = 0;
        data    = '0;
        @(negedge clock);
        cpu_addr     = addr;
        cpu_read     = read;
        cpu_uncached = uncached;
        cpu_inval    = inval;
        @(negedge clock);   // Accepted at the edge just passed
        cpu_read  = 1'b0;
        cpu_inval = 1'b0;
        latency   = 1;
        ready     = cpu_ready;
        data      = cpu_data;
        while (!ready && latency < worst_fill) begin
            @(negedge clock);
            latency++;
            ready = cpu_ready;
            data  = cpu_data;
        end
        if (!ready) begin
            errors++;
            $display("Request to address %h got no cpu_ready in %0d cycles", addr, worst_fill);
        end
    endtask

    task automatic read_checked(input word_addr_t addr, input logic uncached, output int latency);
        word_t data;
        run_request(addr, 1'b1, uncached, 1'b0, data, latency);
        check_word("cpu_data", data, model_word(addr));
    endtask

    task automatic invalidate_index(input word_addr_t addr, output int latency);
        word_t data;
        run_request(addr, 1'b0, 1'b0, 1'b1, data, latency);
    endtask

    task automatic cold_miss_test();
        word_addr_t addr;
        int         base;
        int         latency;
        addr = make_addr(20'h00123, 8'h10, 2'd2);
        base = line_reqs;
        read_checked(addr, 1'b0, latency);
        check_count("line requests", line_reqs - base, 1);
        check_addr("mem_addr", last_line_addr, addr);
    endtask

    task automatic line_hit_test();
        int base_line;
        int base_word;
        int latency;
        base_line = line_reqs;
        base_word = word_reqs;
        for (int o = 0; o < words_per_line; o++) begin
            read_checked(make_addr(20'h00123, 8'h10, offset_t'(o)), 1'b0, latency);
            check_count("hit latency", latency, 1);
        end
        check_count("line requests", line_reqs - base_line, 0);
        check_count("word requests", word_reqs - base_word, 0);
    endtask

    task automatic uncached_test();
        word_addr_t cached;
        word_addr_t fresh;
        int         base_line;
        int         base_word;
        int         latency;
        cached    = make_addr(20'h00123, 8'h10, 2'd1);
        fresh     = make_addr(20'h00456, 8'h20, 2'd3);
        base_line = line_reqs;
        base_word = word_reqs;
        read_checked(cached, 1'b1, latency);
        check_count("word requests", word_reqs - base_word, 1);
        check_addr("mem_addr", last_word_addr, cached);
        read_checked(cached, 1'b1, latency);
        check_count("word requests", word_reqs - base_word, 2);
        read_checked(fresh, 1'b1, latency);   // Allocates nothing
        read_checked(fresh, 1'b0, latency);
        check_count("line requests", line_reqs - base_line, 1);
        check_count("word requests", word_reqs - base_word, 3);
    endtask

    task automatic lru_test();
        word_addr_t x;
        word_addr_t y;
        word_addr_t z;
        int         base;
        int         latency;
        x = make_addr(20'h0aaa0, 8'h40, 2'd0);
        y = make_addr(20'h0bbb0, 8'h40, 2'd1);
        z = make_addr(20'h0ccc0, 8'h40, 2'd2);
        read_checked(x, 1'b0, latency);
        read_checked(y, 1'b0, latency);
        base = line_reqs;
        read_checked(x, 1'b0, latency);   // X now most recent
        read_checked(z, 1'b0, latency);
        check_count("line requests", line_reqs - base, 1);
        base = line_reqs;
        read_checked(x, 1'b0, latency);
        check_count("line requests", line_reqs - base, 0);
        read_checked(y, 1'b0, latency);
        check_count("line requests", line_reqs - base, 1);
    endtask

    task automatic inval_test();
        word_addr_t p;
        word_addr_t q;
        int         base;
        int         latency;
        p = make_addr(20'h00301, 8'h60, 2'd0);
        q = make_addr(20'h00302, 8'h60, 2'd3);
        read_checked(p, 1'b0, latency);
        read_checked(q, 1'b0, latency);
        base = line_reqs;
        read_checked(p, 1'b0, latency);
        read_checked(q, 1'b0, latency);
        check_count("line requests", line_reqs - base, 0);
        invalidate_index(make_addr(20'h00001, 8'h60, 2'd0), latency);
        check_count("inval latency", latency, 2);
        invalidate_index(make_addr(20'h00000, 8'h60, 2'd0), latency);
        check_count("inval latency", latency, 2);
        base = line_reqs;
        read_checked(p, 1'b0, latency);
        read_checked(q, 1'b0, latency);
        check_count("line requests", line_reqs - base, 2);
    endtask

    task automatic scrambled_fill_test();
        tag_t    tag;
        index_t  index;
        offset_t first;
        int      base;
        int      latency;
        for (int k = 0; k < 6; k++) begin
            tag   = tag_t'($random(seed));
            first = offset_t'($random(seed));
            index = index_t'(8'h80 + k);   // Sets untouched by earlier tests
            base  = line_reqs;
            read_checked(make_addr(tag, index, first), 1'b0, latency);
            for (int o = 0; o < words_per_line; o++) begin
                read_checked(make_addr(tag, index, offset_t'(o)), 1'b0, latency);
            end
            check_count("line requests", line_reqs - base, 1);
        end
    endtask

    initial begin
        cpu_addr     = '0;
        cpu_read     = 1'b0;
        cpu_uncached = 1'b0;
        cpu_inval    = 1'b0;
        wait (!reset);
        @(negedge clock);
        cold_miss_test();
        line_hit_test();
        uncached_test();
        lru_test();
        inval_test();
        scrambled_fill_test();
        $display("Checks %0d, errors %0d", checks, errors);
        if (errors == 0) begin
            $display("Test passed");
        end else begin
            $display("Test failed");
        end
        $finish;
    end

    initial begin
        #(timeout_ns);
        $display("Watchdog expired after %0d ns, tests did not finish", timeout_ns);
        $display("Test failed");
        $finish;
    end

endmodule

`default_nettype wire

/* icache_props.sv */
`timescale 1ns/1ns
`default_nettype none

module icache_props (
    input wire logic clock,
    input wire logic reset,
    input wire logic cpu_ready,
    input wire logic mem_read_line,
    input wire logic mem_read_word
);

    localparam int unsigned fill_bound = 24;   // Cycles from line request to cpu_ready

    int unsigned fill_wait;
    logic        fill_open;

    always_ff @(posedge clock) begin
        if (reset) begin
            fill_open <= 1'b0;
            fill_wait <= 0;
        end else if (mem_read_line) begin
            fill_open <= 1'b1;
            fill_wait <= 0;
        end else if (fill_open && cpu_ready) begin
            fill_open <= 1'b0;
        end else if (fill_open) begin
            fill_wait <= fill_wait + 1;
        end
    end

    one_request_kind: assert property (@(posedge clock) disable iff (reset)
        !(mem_read_line && mem_read_word))
        else $error("mem_read_line and mem_read_word high together");

    no_request_on_ready: assert property (@(posedge clock) disable iff (reset)
        cpu_ready |-> !(mem_read_line || mem_read_word))
        else $error("memory request while cpu_ready is high");

    fill_completes: assert property (@(posedge clock) disable iff (reset)
        fill_open |-> (fill_wait < fill_bound))
        else $error("no cpu_ready within %0d cycles of a line request", fill_bound);

endmodule

bind icache_top icache_props props (
    .clock         (clock),
    .reset         (reset),
    .cpu_ready     (cpu_ready),
    .mem_read_line (mem_read_line),
    .mem_read_word (mem_read_word)
);

`default_nettype wire

/* icache_clock_gen.sv */
`timescale 1ns/1ns
`default_nettype none

module icache_clock_gen #(
    parameter int period_ns    = 8,
    parameter int reset_cycles = 2
) (
    output logic clock,
    output logic reset
);

    initial begin
        clock = 1'b0;
        forever #(period_ns / 2) clock = ~clock;
    end

    // Released on a falling edge, like every other testbench input
    initial begin
        reset = 1'b1;
        repeat (reset_cycles) @(negedge clock);
        reset = 1'b0;
    end

endmodule

`default_nettype wire

/* icache_top.sv */
`timescale 1ns/1ns
`default_nettype none

module icache_top
    import icache_geom_pkg::*, icache_ctrl_pkg::*;
(
    input  logic       clock,
    input  logic       reset,
    input  word_addr_t cpu_addr,
    input  logic       cpu_read,
    input  logic       cpu_uncached,
    input  logic       cpu_inval,
    output word_t      cpu_data,
    output logic       cpu_ready,
    output word_addr_t mem_addr,
    output logic       mem_read_line,
    output logic       mem_read_word,
    input  word_t      mem_data,
    input  offset_t    mem_offset,
    input  logic       mem_ready
);

    index_t   way_index;
    tag_t     way_tag;
    offset_t  way_offset;
    way_cmd_t cmd_a;
    way_cmd_t cmd_b;
    word_t    word_a;
    word_t    word_b;
    logic     hit_a;
    logic     hit_b;
    logic     valid_a;
    logic     valid_b;
    logic     victim_b;
    logic     touch;

    icache_ctrl ctrl (
        .clock         (clock),
        .reset         (reset),
        .cpu_addr      (cpu_addr),
        .cpu_read      (cpu_read),
        .cpu_uncached  (cpu_uncached),
        .cpu_inval     (cpu_inval),
        .cpu_data      (cpu_data),
        .cpu_ready     (cpu_ready),
        .mem_addr      (mem_addr),
        .mem_read_line (mem_read_line),
        .mem_read_word (mem_read_word),
        .mem_ready     (mem_ready),
        .mem_offset    (mem_offset),
        .mem_data      (mem_data),
        .hit_a         (hit_a),
        .hit_b         (hit_b),
        .word_a        (word_a),
        .word_b        (word_b),
        .victim_b      (victim_b),
        .way_index     (way_index),
        .way_tag       (way_tag),
        .way_offset    (way_offset),
        .cmd_a         (cmd_a),
        .cmd_b         (cmd_b),
        .touch         (touch)
    );

    icache_lru lru (
        .clock    (clock),
        .reset    (reset),
        .index    (way_index),
        .valid_a  (valid_a),
        .valid_b  (valid_b),
        .hit_a    (hit_a),
        .hit_b    (hit_b),
        .touch    (touch),
        .victim_b (victim_b)
    );

    // Both ways take line words straight from the memory bus
    icache_way way_a (
        .clock       (clock),
        .reset       (reset),
        .index       (way_index),
        .tag         (way_tag),
        .offset      (way_offset),
        .fill_offset (mem_offset),
        .fill_data   (mem_data),
        .cmd         (cmd_a),
        .word        (word_a),
        .hit         (hit_a),
        .valid       (valid_a)
    );

    icache_way way_b (
        .clock       (clock),
        .reset       (reset),
        .index       (way_index),
        .tag         (way_tag),
        .offset      (way_offset),
        .fill_offset (mem_offset),
        .fill_data   (mem_data),
        .cmd         (cmd_b),
        .word        (word_b),
        .hit         (hit_b),
        .valid       (valid_b)
    );

endmodule

`default_nettype wire

/* icache_ctrl.sv */
`timescale 1ns/1ns
`default_nettype none

module icache_ctrl
    import icache_geom_pkg::*, icache_ctrl_pkg::*;
(
    input  logic       clock,
    input  logic       reset,
    input  word_addr_t cpu_addr,
    input  logic       cpu_read,
    input  logic       cpu_uncached,
    input  logic       cpu_inval,
    output word_t      cpu_data,
    output logic       cpu_ready,
    output word_addr_t mem_addr,
    output logic       mem_read_line,
    output logic       mem_read_word,
    input  logic       mem_ready,
    input  offset_t    mem_offset,
    input  word_t      mem_data,
    input  logic       hit_a,
    input  logic       hit_b,
    input  word_t      word_a,
    input  word_t      word_b,
    input  logic       victim_b,
    output index_t     way_index,
    output tag_t       way_tag,
    output offset_t    way_offset,
    output way_cmd_t   cmd_a,
    output way_cmd_t   cmd_b,
    output logic       touch
);

    ctrl_state_t state;
    ctrl_state_t next_state;
    ctrl_state_t request_state;

    word_addr_t  saved_addr;
    logic        saved_uncached;
    word_t       captured_word;
    logic        fill_victim_b;
    offset_t     fill_count;

    logic        hit_any;
    logic        read_hit;
    logic        can_accept;
    logic        new_req;
    logic        present_new;
    logic        last_word;
    logic        capture;
    logic        inval_sel_a;
    word_addr_t  way_addr;

    assign hit_any  = hit_a || hit_b;
    assign read_hit = (state == st_check) && !saved_uncached && hit_any;

    // States where the previous request is finished this cycle
    assign present_new = (state == st_idle) || (state == st_word_done) ||
                         (state == st_line_done) || (state == st_recover);
    assign can_accept  = present_new || read_hit;
    assign new_req     = can_accept && (cpu_read || cpu_inval);

    // Invalidate wins if both pulses arrive together
    assign request_state = cpu_inval ? st_inval : (cpu_read ? st_check : st_idle);

    // Hit check in st_check always uses the saved address
    assign way_addr   = present_new ? cpu_addr : saved_addr;
    assign way_index  = addr_index(way_addr);
    assign way_tag    = addr_tag(way_addr);
    assign way_offset = addr_offset(way_addr);

    assign mem_addr      = saved_addr;
    assign mem_read_line = (state == st_check) && !saved_uncached && !hit_any;
    assign mem_read_word = (state == st_check) && saved_uncached;
    assign touch         = (state == st_check) && !saved_uncached;

    assign cpu_ready = read_hit || (state == st_word_done) ||
                       (state == st_line_done) || (state == st_recover);
    assign cpu_data  = ((state == st_word_done) || (state == st_line_done)) ?
                       captured_word : (hit_a ? word_a : word_b);

    assign last_word   = (fill_count == offset_t'(words_per_line - 1));
    assign capture     = mem_ready && ((state == st_wait_word) ||
                         ((state == st_fill) && (mem_offset == addr_offset(saved_addr))));
    assign inval_sel_a = saved_addr[way_select_bit];

    always_comb begin
        next_state = state;
        case (state)
            st_idle:      next_state = request_state;
            st_check: begin
                if (saved_uncached) begin
                    next_state = st_wait_word;   // Memory read even when cached
                end else if (hit_any) begin
                    next_state = request_state;
                end else begin
                    next_state = st_fill;
                end
            end
            st_wait_word: next_state = mem_ready ? st_word_done : st_wait_word;
            st_fill:      next_state = (mem_ready && last_word) ? st_line_done : st_fill;
            st_word_done: next_state = request_state;
            st_line_done: next_state = request_state;
            st_inval:     next_state = st_recover;
            st_recover:   next_state = request_state;
            default:      next_state = st_idle;
        endcase
    end

    always_comb begin
        cmd_a = cmd_none;
        cmd_b = cmd_none;
        if ((state == st_fill) && mem_ready) begin
            if (fill_victim_b) begin
                cmd_b.fill_word = 1'b1;
                cmd_b.validate  = last_word;
            end else begin
                cmd_a.fill_word = 1'b1;
                cmd_a.validate  = last_word;
            end
        end
        if (state == st_inval) begin
            if (inval_sel_a) begin
                cmd_a.invalidate = 1'b1;
            end else begin
                cmd_b.invalidate = 1'b1;
            end
        end
    end

    always_ff @(posedge clock) begin
        if (reset) begin
            state <= st_idle;
        end else begin
            state <= next_state;
        end
    end

    // Counts arriving line words, any offset order
    always_ff @(posedge clock) begin
        if (reset) begin
            fill_count <= '0;
        end else if (mem_read_line) begin
            fill_count <= '0;
        end else if ((state == st_fill) && mem_ready) begin
            fill_count <= fill_count + offset_t'(1);
        end
    end

    always_ff @(posedge clock) begin
        if (new_req) begin
            saved_addr     <= cpu_addr;
            saved_uncached <= cpu_uncached;
        end
        if (mem_read_line) begin
            fill_victim_b <= victim_b;   // Held for the whole fill
        end
        if (capture) begin
            captured_word <= mem_data;
        end
    end

endmodule

`default_nettype wire

/* icache_lru.sv */
`timescale 1ns/1ns
`default_nettype none

module icache_lru
    import icache_geom_pkg::*;
(
    input  logic   clock,
    input  logic   reset,
    input  index_t index,
    input  logic   valid_a,
    input  logic   valid_b,
    input  logic   hit_a,
    input  logic   hit_b,
    input  logic   touch,
    output logic   victim_b
);

    // One bit per set, high when way B goes next
    logic [num_sets-1:0] replace_b;

    // Empty ways are filled first, A before B
    assign victim_b = valid_a && (!valid_b || replace_b[index]);

    always_ff @(posedge clock) begin
        if (reset) begin
            replace_b <= '0;
        end else if (touch) begin
            if (hit_a) begin
                replace_b[index] <= 1'b1;
            end else if (hit_b) begin
                replace_b[index] <= 1'b0;
            end else begin
                replace_b[index] <= !victim_b;   // Miss, the refilled way becomes newest
            end
        end
    end

endmodule

`default_nettype wire

/* icache_way.sv */
`timescale 1ns/1ns
`default_nettype none

module icache_way
    import icache_geom_pkg::*, icache_ctrl_pkg::*;
(
    input  logic     clock,
    input  logic     reset,
    input  index_t   index,
    input  tag_t     tag,
    input  offset_t  offset,
    input  offset_t  fill_offset,
    input  word_t    fill_data,
    input  way_cmd_t cmd,
    output word_t    word,
    output logic     hit,
    output logic     valid
);

    localparam int num_words = num_sets * words_per_line;

    tag_t               tag_mem [num_sets];
    word_t              data_mem [num_words];
    logic [num_sets-1:0] valid_bits;

    logic [$clog2(num_words)-1:0] read_addr;
    logic [$clog2(num_words)-1:0] fill_addr;

    assign read_addr = {index, offset};
    assign fill_addr = {index, fill_offset};

    // Lookup is combinational on the presented index
    assign valid = valid_bits[index];
    assign hit   = valid && (tag_mem[index] == tag);
    assign word  = data_mem[read_addr];

    always_ff @(posedge clock) begin
        if (reset) begin
            valid_bits <= '0;
        end else if (cmd.validate) begin
            valid_bits[index] <= 1'b1;
        end else if (cmd.invalidate) begin
            valid_bits[index] <= 1'b0;
        end
    end

    always_ff @(posedge clock) begin
        if (cmd.validate) begin
            tag_mem[index] <= tag;   // Tag written with the last word of the line
        end
    end

    always_ff @(posedge clock) begin
        if (cmd.fill_word) begin
            data_mem[fill_addr] <= fill_data;
        end
    end

endmodule

`default_nettype wire

/* icache_ctrl_pkg.sv */
`default_nettype none

package icache_ctrl_pkg;

    typedef enum logic [2:0] {
        st_idle,
        st_check,       // Tag compare on the saved address
        st_wait_word,   // Uncached word outstanding
        st_fill,        // Line words arriving
        st_word_done,
        st_line_done,
        st_inval,
        st_recover
    } ctrl_state_t;

    // Command enables sent to one way
    typedef struct packed {
        logic fill_word;
        logic validate;
        logic invalidate;
    } way_cmd_t;

    localparam way_cmd_t cmd_none = '{fill_word: 1'b0, validate: 1'b0, invalidate: 1'b0};

endpackage

`default_nettype wire

/* icache_geom_pkg.sv */
`default_nettype none

package icache_geom_pkg;

    localparam int word_bits      = 32;
    localparam int addr_bits      = 30;   // Word address, byte bits dropped
    localparam int offset_bits    = 2;
    localparam int index_bits     = 8;
    localparam int tag_bits       = addr_bits - index_bits - offset_bits;

    localparam int num_sets       = 256;
    localparam int words_per_line = 4;

    // Lowest tag bit, picks the way for index invalidate
    localparam int way_select_bit = offset_bits + index_bits;

    typedef logic [word_bits-1:0]   word_t;
    typedef logic [addr_bits-1:0]   word_addr_t;
    typedef logic [offset_bits-1:0] offset_t;
    typedef logic [index_bits-1:0]  index_t;
    typedef logic [tag_bits-1:0]    tag_t;

    // Field split of a word address: tag | index | offset
    function automatic offset_t addr_offset(word_addr_t addr);
        return addr[offset_bits-1:0];
    endfunction

    function automatic index_t addr_index(word_addr_t addr);
        return addr[offset_bits +: index_bits];
    endfunction

    function automatic tag_t addr_tag(word_addr_t addr);
        return addr[addr_bits-1 -: tag_bits];
    endfunction

endpackage

`default_nettype wire
